// File: source/debug_pkg.sv
`default_nettype none

package debug_pkg;

    localparam int WORD_BITS      = 32;
    localparam int BYTE_BITS      = 8;
    localparam int NUM_REGS       = 32;
    localparam int NUM_MEM_WORDS  = 16;
    localparam int INSTR_ADDR_BITS = 8;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [WORD_BITS-1:0]               word_t;
    typedef logic [BYTE_BITS-1:0]               byte_t;
    typedef logic [$clog2(NUM_REGS)-1:0]        reg_addr_t;
    typedef logic [$clog2(NUM_MEM_WORDS)-1:0]   mem_addr_t;
    typedef logic [INSTR_ADDR_BITS-1:0]         instr_addr_t;
    typedef logic [$clog2(BYTES_PER_WORD)-1:0]  byte_idx_t;    // byte position inside a word

    localparam byte_idx_t LAST_BYTE = byte_idx_t'(BYTES_PER_WORD - 1);

    // host commands, plain ascii
    localparam byte_t CMD_CONTINUOUS = 8'h63;    // 'c'
    localparam byte_t CMD_STEP       = 8'h73;    // 's'
    localparam byte_t CMD_NEXT       = 8'h6e;    // 'n'
    localparam byte_t CMD_LOAD       = 8'h72;    // 'r'

    localparam word_t HALT_WORD = 32'hffff_ffff;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,     // free running until halt
        ST_STEP,    // waiting for 'n'
        ST_LOAD,    // bytes go to the instruction loader
        ST_DUMP
    } fsm_state_t;

endpackage

`default_nettype wire

// File: source/debug_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module debug_fsm (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire                      i_uart_rx_flag_ready,
    input  wire debug_pkg::byte_t    i_uart_rx_data,
    input  wire                      i_halt,
    input  wire                      i_load_done,
    input  wire                      i_dump_done,
    output logic                     o_uart_rx_reset,
    output logic                     o_ctl_clk_wiz,
    output logic                     o_byte_strobe,
    output logic                     o_dump_start
);

    debug_pkg::fsm_state_t state;
    logic                  step_mode;     // dump returns to step
    logic                  step_pulse;
    logic                  rx_reset;
    logic                  dump_start;
    logic                  rx_seen;

    // a byte counts once; the flag is ignored while the receiver is being cleared
    assign rx_seen = i_uart_rx_flag_ready && !rx_reset;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= debug_pkg::ST_IDLE;
            step_mode  <= 1'b0;
            step_pulse <= 1'b0;
            rx_reset   <= 1'b1;
            dump_start <= 1'b0;
        end else begin
            rx_reset   <= 1'b0;
            step_pulse <= 1'b0;
            dump_start <= 1'b0;
            case (state)
                debug_pkg::ST_IDLE: begin
                    rx_reset <= i_uart_rx_flag_ready;
                    if (rx_seen) begin
                        case (i_uart_rx_data)
                            debug_pkg::CMD_CONTINUOUS: begin
                                state     <= debug_pkg::ST_RUN;
                                step_mode <= 1'b0;
                            end
                            debug_pkg::CMD_STEP: begin
                                state     <= debug_pkg::ST_STEP;
                                step_mode <= 1'b1;
                            end
                            debug_pkg::CMD_LOAD: begin
                                state <= debug_pkg::ST_LOAD;
                            end
                            default: begin
                                state <= debug_pkg::ST_IDLE;    // unknown char dropped
                            end
                        endcase
                    end
                end
                debug_pkg::ST_RUN: begin
                    if (i_halt) begin
                        state      <= debug_pkg::ST_DUMP;
                        dump_start <= 1'b1;
                    end
                end
                debug_pkg::ST_STEP: begin
                    if (step_pulse) begin
                        state      <= debug_pkg::ST_DUMP;    // the single cycle is done
                        dump_start <= 1'b1;
                    end else begin
                        rx_reset <= i_uart_rx_flag_ready;
                        if (rx_seen && i_uart_rx_data == debug_pkg::CMD_NEXT) begin
                            step_pulse <= 1'b1;
                        end
                    end
                end
                debug_pkg::ST_LOAD: begin
                    rx_reset <= i_uart_rx_flag_ready;
                    if (i_load_done) begin
                        state <= debug_pkg::ST_IDLE;
                    end
                end
                debug_pkg::ST_DUMP: begin
                    if (i_dump_done) begin
                        state <= step_mode ? debug_pkg::ST_STEP : debug_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= debug_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign o_uart_rx_reset = rx_reset;
    assign o_ctl_clk_wiz   = (state == debug_pkg::ST_RUN) || step_pulse;
    assign o_byte_strobe   = (state == debug_pkg::ST_LOAD) && rx_seen;
    assign o_dump_start    = dump_start;

    // the processor must be frozen while its state is read out
    a_no_clk_in_dump: assert property (
        @(posedge i_clk) disable iff (i_reset)
        state == debug_pkg::ST_DUMP |-> !o_ctl_clk_wiz
    );

    // every forwarded byte is cleared from the receiver in the next cycle
    a_strobe_in_load: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_byte_strobe |-> (state == debug_pkg::ST_LOAD) ##1 o_uart_rx_reset
    );

endmodule

`default_nettype wire

// File: source/instr_loader.sv
`timescale 1ns/1ps
`default_nettype none

module instr_loader (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_byte_strobe,
    input  wire debug_pkg::byte_t        i_rx_byte,
    output logic                         o_flag_instr_write,
    output debug_pkg::instr_addr_t       o_select_addr_mem_instr,
    output debug_pkg::word_t             o_dato_mem_instruction,
    output logic                         o_load_done
);

    debug_pkg::word_t       word_reg;
    debug_pkg::byte_idx_t   byte_cnt;
    debug_pkg::instr_addr_t addr;
    logic                   word_full;
    logic                   instr_write;
    logic                   load_done;

    // msb first, so each new byte pushes the older ones up
    always_ff @(posedge i_clk) begin
        if (i_byte_strobe) begin
            word_reg <= {word_reg[debug_pkg::WORD_BITS-debug_pkg::BYTE_BITS-1:0], i_rx_byte};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt    <= '0;
            word_full   <= 1'b0;
            instr_write <= 1'b0;
            addr        <= '0;
            load_done   <= 1'b0;
        end else begin
            load_done   <= 1'b0;
            word_full   <= i_byte_strobe && (byte_cnt == debug_pkg::LAST_BYTE);
            instr_write <= word_full;
            if (i_byte_strobe) begin
                byte_cnt <= byte_cnt + 1'b1;    // wraps after the fourth byte
            end
            if (instr_write) begin
                if (word_reg == debug_pkg::HALT_WORD) begin
                    addr      <= '0;    // halt ends the program
                    load_done <= 1'b1;
                end else begin
                    addr <= addr + debug_pkg::instr_addr_t'(debug_pkg::BYTES_PER_WORD);
                end
            end
        end
    end

    assign o_flag_instr_write      = instr_write;
    assign o_select_addr_mem_instr = addr;
    assign o_dato_mem_instruction  = word_reg;
    assign o_load_done             = load_done;

    a_addr_aligned: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_flag_instr_write |-> o_select_addr_mem_instr[1:0] == 2'b00 ##1
            o_select_addr_mem_instr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: source/dump_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
    input  wire                       i_clk,
    input  wire                       i_reset,
    input  wire                       i_dump_start,
    input  wire                       i_word_sent,
    input  wire debug_pkg::word_t     i_mips_pc,
    input  wire debug_pkg::word_t     i_clk_wiz_count,
    input  wire debug_pkg::word_t     i_data_bankregisters,
    input  wire debug_pkg::word_t     i_data_mem,
    output debug_pkg::reg_addr_t      o_select_addr_registers,
    output debug_pkg::mem_addr_t      o_select_addr_memdata,
    output debug_pkg::word_t          o_dump_word,
    output logic                      o_word_valid,
    output logic                      o_dump_done
);

    typedef enum logic [1:0] {
        SEC_PC,
        SEC_CYCLES,
        SEC_REGS,
        SEC_MEM
    } section_t;

    section_t             section;
    debug_pkg::reg_addr_t reg_idx;
    debug_pkg::mem_addr_t mem_idx;
    debug_pkg::word_t     selected;
    logic                 fetch;        // read addresses are settled, latch this cycle
    logic                 in_flight;
    logic                 last_word;

    always_comb begin
        case (section)
            SEC_PC:     selected = i_mips_pc;
            SEC_CYCLES: selected = i_clk_wiz_count;
            SEC_REGS:   selected = i_data_bankregisters;
            default:    selected = i_data_mem;
        endcase
    end

    assign last_word = (section == SEC_MEM) &&
                       (mem_idx == debug_pkg::mem_addr_t'(debug_pkg::NUM_MEM_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            section      <= SEC_PC;
            reg_idx      <= '0;
            mem_idx      <= '0;
            fetch        <= 1'b0;
            in_flight    <= 1'b0;
            o_word_valid <= 1'b0;
            o_dump_done  <= 1'b0;
        end else begin
            o_word_valid <= 1'b0;
            o_dump_done  <= 1'b0;
            if (i_dump_start) begin
                fetch <= 1'b1;
            end
            if (fetch) begin
                fetch        <= 1'b0;
                o_word_valid <= 1'b1;
            end
            if (o_word_valid) begin
                in_flight <= 1'b1;
            end else if (in_flight && i_word_sent) begin
                in_flight <= 1'b0;
                if (last_word) begin
                    section     <= SEC_PC;
                    reg_idx     <= '0;
                    mem_idx     <= '0;
                    o_dump_done <= 1'b1;
                end else begin
                    fetch <= 1'b1;
                    case (section)
                        SEC_PC:     section <= SEC_CYCLES;
                        SEC_CYCLES: section <= SEC_REGS;
                        SEC_REGS: begin
                            reg_idx <= reg_idx + 1'b1;
                            if (reg_idx == debug_pkg::reg_addr_t'(debug_pkg::NUM_REGS - 1)) begin
                                section <= SEC_MEM;
                            end
                        end
                        default:    mem_idx <= mem_idx + 1'b1;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch) begin
            o_dump_word <= selected;
        end
    end

    assign o_select_addr_registers = reg_idx;
    assign o_select_addr_memdata   = mem_idx;

    // the serializer holds only one word, so the next may follow only its word_sent
    a_one_word_in_flight: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_word_valid |-> !in_flight
    );

endmodule

`default_nettype wire

// File: source/tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
    input  wire                      i_clk,
    input  wire                      i_reset,
    input  wire debug_pkg::word_t    i_word,
    input  wire                      i_word_valid,
    input  wire                      i_uart_tx_done,
    output debug_pkg::byte_t         o_uart_tx_data,
    output logic                     o_flag_tx_ready,
    output logic                     o_word_sent
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,    // byte offered, waiting for the transmitter to go busy
        TX_WAIT     // transmitter busy
    } tx_state_t;

    tx_state_t            state;
    debug_pkg::word_t     shift_reg;
    debug_pkg::byte_idx_t byte_idx;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= TX_IDLE;
            byte_idx    <= '0;
            o_word_sent <= 1'b0;
        end else begin
            o_word_sent <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (i_word_valid) begin
                        state    <= TX_SEND;
                        byte_idx <= '0;
                    end
                end
                TX_SEND: begin
                    if (!i_uart_tx_done) begin
                        state <= TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    if (i_uart_tx_done) begin
                        if (byte_idx == debug_pkg::LAST_BYTE) begin
                            state       <= TX_IDLE;
                            o_word_sent <= 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= TX_SEND;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_word_valid) begin
            shift_reg <= i_word;
        end else if (state == TX_WAIT && i_uart_tx_done) begin
            shift_reg <= shift_reg << debug_pkg::BYTE_BITS;    // next byte to the top
        end
    end

    assign o_uart_tx_data  = shift_reg[debug_pkg::WORD_BITS-1 -: debug_pkg::BYTE_BITS];
    assign o_flag_tx_ready = (state == TX_SEND) && i_uart_tx_done;

    // a byte is never offered to a busy transmitter
    a_ready_not_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !i_uart_tx_done |-> !o_flag_tx_ready
    );

endmodule

`default_nettype wire

// File: source/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire debug_pkg::word_t        i_clk_wiz_count,
    input  wire                          i_uart_rx_flag_ready,
    input  wire debug_pkg::byte_t        i_uart_rx_data,
    input  wire                          i_uart_tx_done,
    input  wire debug_pkg::word_t        i_mips_pc,
    input  wire debug_pkg::word_t        i_data_bankregisters,
    input  wire debug_pkg::word_t        i_data_mem,
    input  wire                          i_halt,
    output logic                         o_ctl_clk_wiz,
    output logic                         o_uart_rx_reset,
    output logic                         o_flag_tx_ready,
    output debug_pkg::byte_t             o_uart_tx_data,
    output debug_pkg::mem_addr_t         o_select_addr_memdata,
    output debug_pkg::reg_addr_t         o_select_addr_registers,
    output logic                         o_flag_instr_write,
    output debug_pkg::instr_addr_t       o_select_addr_mem_instr,
    output debug_pkg::word_t             o_dato_mem_instruction
);

    logic             byte_strobe;
    logic             load_done;
    logic             dump_start;
    logic             dump_done;
    logic             word_valid;
    logic             word_sent;
    debug_pkg::word_t dump_word;

    debug_fsm u_fsm (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_uart_rx_flag_ready (i_uart_rx_flag_ready),
        .i_uart_rx_data       (i_uart_rx_data),
        .i_halt               (i_halt),
        .i_load_done          (load_done),
        .i_dump_done          (dump_done),
        .o_uart_rx_reset      (o_uart_rx_reset),
        .o_ctl_clk_wiz        (o_ctl_clk_wiz),
        .o_byte_strobe        (byte_strobe),
        .o_dump_start         (dump_start)
    );

    instr_loader u_loader (
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_byte_strobe           (byte_strobe),
        .i_rx_byte               (i_uart_rx_data),
        .o_flag_instr_write      (o_flag_instr_write),
        .o_select_addr_mem_instr (o_select_addr_mem_instr),
        .o_dato_mem_instruction  (o_dato_mem_instruction),
        .o_load_done             (load_done)
    );

    dump_sequencer u_sequencer (
        .i_clk                   (i_clk),
        .i_reset                 (i_reset),
        .i_dump_start            (dump_start),
        .i_word_sent             (word_sent),
        .i_mips_pc               (i_mips_pc),
        .i_clk_wiz_count         (i_clk_wiz_count),
        .i_data_bankregisters    (i_data_bankregisters),
        .i_data_mem              (i_data_mem),
        .o_select_addr_registers (o_select_addr_registers),
        .o_select_addr_memdata   (o_select_addr_memdata),
        .o_dump_word             (dump_word),
        .o_word_valid            (word_valid),
        .o_dump_done             (dump_done)
    );

    tx_serializer u_serializer (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_word          (dump_word),
        .i_word_valid    (word_valid),
        .i_uart_tx_done  (i_uart_tx_done),
        .o_uart_tx_data  (o_uart_tx_data),
        .o_flag_tx_ready (o_flag_tx_ready),
        .o_word_sent     (word_sent)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk
);

    localparam time HALF_PERIOD = 4ns;    // 8 ns period

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_unit;

    localparam int CLK_PERIOD_NS  = 8;
    localparam int DUMP_WORDS     = 2 + debug_pkg::NUM_REGS + debug_pkg::NUM_MEM_WORDS;
    localparam int DUMP_BYTES     = DUMP_WORDS * debug_pkg::BYTES_PER_WORD;
    localparam int MAX_TX_CYCLES  = 16;    // busy time plus serializer handshake per byte
    localparam int NUM_DUMPS      = 4;
    localparam int WATCHDOG_NS    = (NUM_DUMPS * DUMP_BYTES * MAX_TX_CYCLES + 4000) * CLK_PERIOD_NS;
    localparam int NUM_LOAD_WORDS = 5;
    localparam int RX_TIMEOUT     = 50;
    localparam int RNG_SEED       = 32'h6557_d8de;

    logic                   clk;
    logic                   reset;
    logic                   rx_flag_ready;
    debug_pkg::byte_t       rx_data;
    logic                   tx_done;
    logic                   halt;
    debug_pkg::word_t       mips_pc;
    debug_pkg::word_t       cycle_count;
    debug_pkg::word_t       reg_data;
    debug_pkg::word_t       mem_data;
    logic                   ctl_clk_wiz;
    logic                   uart_rx_reset;
    logic                   flag_tx_ready;
    logic                   flag_instr_write;
    debug_pkg::byte_t       tx_data;
    debug_pkg::mem_addr_t   mem_sel;
    debug_pkg::reg_addr_t   reg_sel;
    debug_pkg::instr_addr_t instr_addr;
    debug_pkg::word_t       instr_data;

    debug_pkg::word_t       regs [debug_pkg::NUM_REGS];
    debug_pkg::word_t       mem [debug_pkg::NUM_MEM_WORDS];
    debug_pkg::word_t       load_words [NUM_LOAD_WORDS];
    debug_pkg::byte_t       tx_bytes [$];
    debug_pkg::byte_t       exp_bytes [$];
    debug_pkg::instr_addr_t wr_addr [$];
    debug_pkg::word_t       wr_data [$];
    logic                   frozen;      // processor clock forbidden
    logic                   quiet;       // no clock, write or transmission allowed
    logic                   stepping;
    int                     errors;
    int                     errors_before;
    int                     tests_run;
    int                     tests_failed;
    int                     tx_busy;

    tb_clock u_clock (
        .o_clk (clk)
    );

    debug_unit uut (
        .i_clk                   (clk),
        .i_reset                 (reset),
        .i_clk_wiz_count         (cycle_count),
        .i_uart_rx_flag_ready    (rx_flag_ready),
        .i_uart_rx_data          (rx_data),
        .i_uart_tx_done          (tx_done),
        .i_mips_pc               (mips_pc),
        .i_data_bankregisters    (reg_data),
        .i_data_mem              (mem_data),
        .i_halt                  (halt),
        .o_ctl_clk_wiz           (ctl_clk_wiz),
        .o_uart_rx_reset         (uart_rx_reset),
        .o_flag_tx_ready         (flag_tx_ready),
        .o_uart_tx_data          (tx_data),
        .o_select_addr_memdata   (mem_sel),
        .o_select_addr_registers (reg_sel),
        .o_flag_instr_write      (flag_instr_write),
        .o_select_addr_mem_instr (instr_addr),
        .o_dato_mem_instruction  (instr_data)
    );

    // register file and data memory answer combinationally
    assign reg_data = regs[reg_sel];
    assign mem_data = mem[mem_sel];

    always @(negedge clk) begin
        if (!reset && ctl_clk_wiz) begin
            cycle_count <= cycle_count + 1'b1;
            mips_pc     <= mips_pc + 32'd4;
        end
    end

    // uart transmitter busy for a random 2 to 9 cycles per byte
    always @(negedge clk) begin
        if (flag_tx_ready) begin
            tx_bytes.push_back(tx_data);
            tx_done = 1'b0;
            tx_busy = 2 + ($urandom % 8);
            repeat (tx_busy) @(negedge clk);
            tx_done = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (flag_instr_write) begin
            wr_addr.push_back(instr_addr);
            wr_data.push_back(instr_data);
        end
    end

    a_clock_held: assert property (
        @(posedge clk) disable iff (reset) (frozen || quiet) |-> !ctl_clk_wiz
    ) else begin
        $display("FAIL %0t o_ctl_clk_wiz got %b expected 0", $time, ctl_clk_wiz);
        errors++;
    end

    a_single_step: assert property (
        @(posedge clk) disable iff (reset) (stepping && ctl_clk_wiz) |=> !ctl_clk_wiz
    ) else begin
        $display("FAIL %0t o_ctl_clk_wiz got %b expected 0 after one step", $time, ctl_clk_wiz);
        errors++;
    end

    a_no_tx: assert property (
        @(posedge clk) disable iff (reset) quiet |-> !flag_tx_ready
    ) else begin
        $display("FAIL %0t o_flag_tx_ready got %b expected 0", $time, flag_tx_ready);
        errors++;
    end

    a_no_write: assert property (
        @(posedge clk) disable iff (reset) quiet |-> !flag_instr_write
    ) else begin
        $display("FAIL %0t o_flag_instr_write got %b expected 0", $time, flag_instr_write);
        errors++;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        errors_before = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // called on a falling edge and returns on one
    task automatic send_byte(input debug_pkg::byte_t b);
        int waited;
        rx_data       = b;
        rx_flag_ready = 1'b1;
        waited        = 1;
        @(negedge clk);
        while (!uart_rx_reset && waited < RX_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (uart_rx_reset) else begin
            $display("at %0t byte %h was never cleared from the receiver", $time, b);
            errors++;
        end
        rx_flag_ready = 1'b0;
        @(negedge clk);    // flag low for a cycle between bytes
    endtask

    task automatic send_word(input debug_pkg::word_t w);
        for (int b = debug_pkg::BYTES_PER_WORD - 1; b >= 0; b--) begin
            send_byte(w[8*b +: 8]);
        end
    endtask

    task automatic push_word(input debug_pkg::word_t w);
        for (int b = debug_pkg::BYTES_PER_WORD - 1; b >= 0; b--) begin
            exp_bytes.push_back(w[8*b +: 8]);
        end
    endtask

    task automatic expect_dump();
        exp_bytes.delete();
        push_word(mips_pc);
        push_word(cycle_count);
        for (int r = 0; r < debug_pkg::NUM_REGS; r++) begin
            push_word(regs[r]);
        end
        for (int m = 0; m < debug_pkg::NUM_MEM_WORDS; m++) begin
            push_word(mem[m]);
        end
    endtask

    task automatic collect_dump();
        int waited;
        waited = 0;
        while (tx_bytes.size() < DUMP_BYTES && waited < DUMP_BYTES * MAX_TX_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        repeat (40) @(negedge clk);    // anything extra would show up here
        check_value("dump byte count", tx_bytes.size(), DUMP_BYTES);
        for (int i = 0; i < DUMP_BYTES && i < tx_bytes.size(); i++) begin
            check_value($sformatf("o_uart_tx_data byte %0d", i), tx_bytes[i], exp_bytes[i]);
        end
        tx_bytes.delete();
    endtask

    task automatic run_continuous(input int cycles);
        halt = 1'b0;
        send_byte(debug_pkg::CMD_CONTINUOUS);
        check_value("o_ctl_clk_wiz", ctl_clk_wiz, 1);
        repeat (cycles) begin
            @(negedge clk);
            check_value("o_ctl_clk_wiz", ctl_clk_wiz, 1);
        end
        halt = 1'b1;
        @(negedge clk);
        check_value("o_ctl_clk_wiz", ctl_clk_wiz, 0);
        frozen = 1'b1;
        expect_dump();
        collect_dump();
        frozen = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int               waited;
        debug_pkg::word_t count_before;
        void'($urandom(RNG_SEED));
        reset         = 1'b1;
        rx_flag_ready = 1'b0;
        rx_data       = '0;
        tx_done       = 1'b1;
        halt          = 1'b0;
        mips_pc       = '0;
        cycle_count   = '0;
        frozen        = 1'b0;
        quiet         = 1'b0;
        stepping      = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int r = 0; r < debug_pkg::NUM_REGS; r++) begin
            regs[r] = $urandom();
        end
        for (int m = 0; m < debug_pkg::NUM_MEM_WORDS; m++) begin
            mem[m] = $urandom();
        end

        start_test();
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("o_uart_rx_reset", uart_rx_reset, 1);
        reset = 1'b0;
        @(negedge clk);
        check_value("o_ctl_clk_wiz", ctl_clk_wiz, 0);
        check_value("o_flag_tx_ready", flag_tx_ready, 0);
        check_value("o_flag_instr_write", flag_instr_write, 0);
        check_value("o_uart_rx_reset", uart_rx_reset, 0);
        check_value("o_select_addr_registers", reg_sel, 0);
        check_value("o_select_addr_memdata", mem_sel, 0);
        check_value("o_select_addr_mem_instr", instr_addr, 0);
        send_byte(8'h0d);    // carriage return is ignored
        report_test("reset");

        start_test();
        wr_addr.delete();
        wr_data.delete();
        for (int w = 0; w < NUM_LOAD_WORDS - 1; w++) begin
            load_words[w] = $urandom() & 32'h7fff_ffff;    // never the halt word
        end
        load_words[NUM_LOAD_WORDS-1] = debug_pkg::HALT_WORD;
        send_byte(debug_pkg::CMD_LOAD);
        for (int w = 0; w < NUM_LOAD_WORDS; w++) begin
            send_word(load_words[w]);
        end
        waited = 0;
        while (wr_addr.size() < NUM_LOAD_WORDS && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        check_value("instruction write count", wr_addr.size(), NUM_LOAD_WORDS);
        for (int w = 0; w < NUM_LOAD_WORDS && w < wr_addr.size(); w++) begin
            check_value("o_select_addr_mem_instr", wr_addr[w], 4 * w);
            check_value("o_dato_mem_instruction", wr_data[w], load_words[w]);
        end
        check_value("o_select_addr_mem_instr", instr_addr, 0);
        run_continuous(3);
        report_test("load");

        start_test();
        run_continuous(37);
        report_test("continuous run");

        start_test();
        wr_addr.delete();
        count_before = cycle_count;
        quiet = 1'b1;
        send_byte(8'h78);    // 'x'
        send_byte(debug_pkg::CMD_NEXT);    // only meaningful in step mode
        send_byte(8'h00);
        send_byte(8'hff);
        send_byte(8'h20);    // enough bytes to fill a word if 'x' started a load
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        check_value("transmitted bytes", tx_bytes.size(), 0);
        check_value("instruction writes", wr_addr.size(), 0);
        check_value("i_clk_wiz_count", cycle_count, count_before);
        report_test("unknown characters");

        start_test();
        halt   = 1'b0;
        frozen = 1'b1;
        send_byte(debug_pkg::CMD_STEP);
        repeat (10) @(negedge clk);
        stepping = 1'b1;
        for (int s = 0; s < 2; s++) begin
            count_before = cycle_count;
            frozen = 1'b0;
            send_byte(debug_pkg::CMD_NEXT);
            frozen = 1'b1;
            check_value("enabled cycles per step", cycle_count - count_before, 1);
            expect_dump();
            collect_dump();
        end
        stepping = 1'b0;
        frozen   = 1'b0;
        report_test("step mode");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/debug_pkg.sv
source/debug_fsm.sv
source/instr_loader.sv
source/dump_sequencer.sv
source/tx_serializer.sv
source/debug_unit.sv
tests/tb_clock.sv
tests/tb_debug_unit.sv

// File: Bender.yml
package:
  name: debug_unit

sources:
  - source/debug_pkg.sv
  - source/debug_fsm.sv
  - source/instr_loader.sv
  - source/dump_sequencer.sv
  - source/tx_serializer.sv
  - source/debug_unit.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_debug_unit.sv
